// File: filelist.f
hdl/wisc_pkg.sv
hdl/imm_decode.sv
hdl/instr_decode.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/wisc_pipe_top.sv
dv/wisc_pipe_tb.sv

// File: run.sh
#!/bin/bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module wisc_pipe_tb \
	-f filelist.f \
	-o Vwisc_pipe_tb

# Keep the output even when the simulation stops with an error
sim_out=$(./obj_dir/Vwisc_pipe_tb 2>&1) || true
echo "$sim_out"

grep -q "Regression passed" <<< "$sim_out"

// File: dv/wisc_pipe_tb.sv
`timescale 1ns/1ps

module wisc_pipe_tb;
	import wisc_pkg::*;

	localparam int wb_timeout   = 20;
	localparam int quiet_cycles = 8;

	logic              clk;
	logic              rst;
	logic              instr_valid;
	logic [word_w-1:0] instr;
	logic [word_w-1:0] pc;
	wb_t               wb;
	logic              halted;

	// Shadow copy of the register file, updated at issue time
	logic [word_w-1:0] shadow [num_regs];
	wb_t               exp_q [$];
	int unsigned       issue_q [$];
	int unsigned       cycle_cnt;
	bit                halt_seen;

	wisc_pipe_top wisc_pipe_top_inst (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.wb          (wb),
		.halted      (halted)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	function automatic logic [15:0] rand16();
		logic [31:0] r;
		r = $urandom;
		return r[15:0];
	endfunction

	function automatic logic [15:0] rand_pc();
		logic [31:0] r;
		r = $urandom;
		return {r[15:1], 1'b0};
	endfunction

	function automatic logic [15:0] rol16(logic [15:0] v, logic [3:0] s);
		return (v << s) | (v >> (5'd16 - {1'b0, s}));
	endfunction

	function automatic logic [15:0] ror16(logic [15:0] v, logic [3:0] s);
		return (v >> s) | (v << (5'd16 - {1'b0, s}));
	endfunction

	function automatic logic [15:0] enc_ri(opcode_e op, logic [2:0] rs, logic [2:0] rd,
		logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic logic [15:0] enc_rr(opcode_e op, logic [2:0] rs, logic [2:0] rt,
		logic [2:0] rd, logic [1:0] fn);
		return {op, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] enc_i2(opcode_e op, logic [2:0] rs, logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic logic [15:0] enc_j(opcode_e op, logic [10:0] disp);
		return {op, disp};
	endfunction

	// Register-register group, fn selects within the group
	function automatic logic [15:0] rr_result(opcode_e op, logic [1:0] fn, logic [15:0] a,
		logic [15:0] b);
		if (op == op_alu_rr)
		begin
			case (fn)
				2'd0: return a + b;
				2'd1: return b - a;
				2'd2: return a ^ b;
				default: return a & ~b;
			endcase
		end
		case (fn)
			2'd0: return rol16(a, b[3:0]);
			2'd1: return a << b[3:0];
			2'd2: return ror16(a, b[3:0]);
			default: return a >> b[3:0];
		endcase
	endfunction

	// Expected write-back record from the ISA rules
	function automatic wb_t predict(logic [15:0] word, logic [15:0] addr);
		wb_t         e;
		opcode_e     op;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] s5;
		logic [15:0] z5;
		logic [15:0] s8;
		logic [15:0] s11;
		logic [15:0] link;
		op   = opcode_e'(word[15:11]);
		a    = shadow[word[10:8]];
		b    = shadow[word[7:5]];
		s5   = {{11{word[4]}}, word[4:0]};
		z5   = {11'b0, word[4:0]};
		s8   = {{8{word[7]}}, word[7:0]};
		s11  = {{5{word[10]}}, word[10:0]};
		link = addr + 16'd2;
		e        = '0;
		e.valid  = 1'b1;
		e.writes = 1'b1;
		e.rd     = word[7:5];
		case (op)
			op_addi:  e.data = a + s5;
			op_subi:  e.data = s5 - a;
			op_xori:  e.data = a ^ z5;
			op_andni: e.data = a & ~z5;
			op_roli:  e.data = rol16(a, s5[3:0]);
			op_slli:  e.data = a << s5[3:0];
			op_rori:  e.data = ror16(a, s5[3:0]);
			op_srli:  e.data = a >> s5[3:0];
			op_alu_rr, op_shift_rr:
			begin
				e.rd   = word[4:2];
				e.data = rr_result(op, word[1:0], a, b);
			end
			op_seq:
			begin
				e.rd   = word[4:2];
				e.data = {15'b0, a == b};
			end
			op_slt:
			begin
				e.rd   = word[4:2];
				e.data = {15'b0, $signed(a) < $signed(b)};
			end
			op_sle:
			begin
				e.rd   = word[4:2];
				e.data = {15'b0, $signed(a) <= $signed(b)};
			end
			op_lbi:
			begin
				e.rd   = word[10:8];
				e.data = s8;
			end
			op_slbi:
			begin
				e.rd   = word[10:8];
				e.data = (a << 8) | {8'b0, word[7:0]};
			end
			op_jal:
			begin
				e.rd       = link_reg;
				e.data     = link;
				e.redirect = 1'b1;
				e.target   = link + s11;
			end
			op_jalr:
			begin
				e.rd       = link_reg;
				e.data     = link;
				e.redirect = 1'b1;
				e.target   = a + s8;
			end
			default: e.writes = 1'b0;
		endcase
		// Ops without a register result
		case (op)
			op_beqz: e.redirect = (a == 16'h0);
			op_bnez: e.redirect = (a != 16'h0);
			op_bltz: e.redirect = a[15];
			op_bgez: e.redirect = !a[15];
			op_j:    e.redirect = 1'b1;
			op_jr:   e.redirect = 1'b1;
			op_halt: e.halt = 1'b1;
			op_ld, op_st, op_stu, op_btr, op_sco: e.illegal = 1'b1;
			default: e.halt = 1'b0;
		endcase
		if (op inside {op_beqz, op_bnez, op_bltz, op_bgez})
			e.target = link + s8;
		if (op == op_j)
			e.target = link + s11;
		if (op == op_jr)
			e.target = a + s8;
		if (e.writes)
			shadow[e.rd] = e.data;
		return e;
	endfunction

	task automatic stop_run(string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_mismatch(string name, logic [15:0] got, logic [15:0] exp);
		stop_run($sformatf("FAIL t=%0t %s got %h exp %h", $time, name, got, exp));
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
			stop_run($sformatf("FAIL t=%0t %s got %b exp %b", $time, name, got, exp));
	endtask

	task automatic check_wb(wb_t got, wb_t exp);
		check_bit("wb.valid", got.valid, exp.valid);
		check_bit("wb.illegal", got.illegal, exp.illegal);
		check_bit("wb.halt", got.halt, exp.halt);
		check_bit("wb.writes", got.writes, exp.writes);
		check_bit("wb.redirect", got.redirect, exp.redirect);
		if (exp.writes && got.rd !== exp.rd)
			report_mismatch("wb.rd", {13'b0, got.rd}, {13'b0, exp.rd});
		if (exp.writes && got.data !== exp.data)
			report_mismatch("wb.data", got.data, exp.data);
		if (exp.redirect && got.target !== exp.target)
			report_mismatch("wb.target", got.target, exp.target);
	endtask

	// Moves to just after the next rising edge
	task automatic align();
		@(posedge clk);
		#1;
	endtask

	task automatic issue(logic [15:0] word, logic [15:0] addr);
		wb_t exp;
		// Nothing is expected once HALT has gone in
		if (!halt_seen)
		begin
			exp = predict(word, addr);
			exp_q.push_back(exp);
			issue_q.push_back(cycle_cnt);
		end
		if (word[15:11] == op_halt)
			halt_seen = 1'b1;
		instr       = word;
		pc          = addr;
		instr_valid = 1'b1;
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
	endtask

	task automatic expect_wb();
		wb_t         exp;
		int unsigned t0;
		int          waited;
		waited = 0;
		@(negedge clk);
		while (!wb.valid)
		begin
			if (waited == wb_timeout)
				stop_run("Timed out waiting for wb.valid");
			waited++;
			@(negedge clk);
		end
		if (exp_q.size() == 0)
			stop_run("wb.valid came with no instruction outstanding");
		exp = exp_q.pop_front();
		t0  = issue_q.pop_front();
		check_wb(wb, exp);
		if (exp.halt)
			check_bit("halted", halted, 1'b1);
		if (cycle_cnt != t0 + 2)
			stop_run($sformatf("wb for the instruction issued in cycle %0d came in cycle %0d",
				t0, cycle_cnt));
		// A lone record lasts one cycle
		if (exp_q.size() == 0)
		begin
			@(negedge clk);
			check_bit("wb.valid", wb.valid, 1'b0);
		end
	endtask

	task automatic drain(int n);
		for (int i = 0; i < n; i++)
			expect_wb();
	endtask

	task automatic wait_quiet();
		for (int i = 0; i < quiet_cycles; i++)
		begin
			@(negedge clk);
			if (wb.valid)
				stop_run("wb.valid rose for an instruction issued after HALT");
		end
	endtask

	task automatic test_load_consts();
		logic [15:0] v;
		for (int r = 0; r < num_regs; r++)
		begin
			v = rand16();
			// Odd registers get a negative high byte
			if (r % 2 == 1)
				v[15] = 1'b1;
			align();
			issue(enc_i2(op_lbi, 3'(r), v[15:8]), rand_pc());
			issue(enc_i2(op_slbi, 3'(r), v[7:0]), rand_pc());
			drain(2);
		end
	endtask

	task automatic test_alu_imm();
		opcode_e     ops [8] = '{op_addi, op_subi, op_xori, op_andni,
			op_roli, op_slli, op_rori, op_srli};
		logic [15:0] v;
		for (int round = 0; round < 2; round++)
		begin
			for (int i = 0; i < 8; i++)
			begin
				v = rand16();
				if (round == 1)
					v[4] = 1'b1;
				align();
				issue(enc_ri(ops[i], v[10:8], v[7:5], v[4:0]), rand_pc());
				drain(1);
			end
		end
	endtask

	task automatic test_reg_ops();
		opcode_e     ops [11] = '{op_alu_rr, op_alu_rr, op_alu_rr, op_alu_rr,
			op_shift_rr, op_shift_rr, op_shift_rr, op_shift_rr, op_seq, op_slt, op_sle};
		logic [1:0]  fns [11] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd1, 2'd2, 2'd3,
			2'd0, 2'd0, 2'd0};
		logic [15:0] v;
		logic [2:0]  src;
		logic [2:0]  rt;
		for (int round = 0; round < 2; round++)
		begin
			v   = rand16();
			src = v[2:0];
			align();
			fork
				begin
					for (int i = 0; i < 11; i++)
					begin
						v  = rand16();
						// Second round compares a register with itself
						rt = (round == 1 && i >= 8) ? src : v[7:5];
						issue(enc_rr(ops[i], src, rt, v[4:2], fns[i]), rand_pc());
						src = v[4:2];
					end
				end
				drain(11);
			join
		end
	endtask

	task automatic test_branches();
		opcode_e     br [4] = '{op_beqz, op_bnez, op_bltz, op_bgez};
		logic [15:0] v;
		logic [7:0]  val;
		for (int b = 0; b < 4; b++)
		begin
			for (int kind = 0; kind < 3; kind++)
			begin
				v = rand16();
				case (kind)
					0: val = 8'h00;
					1: val = {1'b0, v[6:0] | 7'h01};
					default: val = {1'b1, v[6:0]};
				endcase
				align();
				issue(enc_i2(op_lbi, 3'd1, val), rand_pc());
				issue(enc_i2(br[b], 3'd1, v[15:8]), rand_pc());
				drain(2);
			end
		end
		v = rand16();
		align();
		issue(enc_j(op_j, v[10:0]), rand_pc());
		drain(1);
		// Link register read back right after each link jump
		v = rand16();
		align();
		issue(enc_j(op_jal, v[10:0]), rand_pc());
		issue(enc_ri(op_addi, link_reg, 3'd2, 5'd0), rand_pc());
		drain(2);
		v = rand16();
		align();
		issue(enc_i2(op_jr, v[10:8], v[7:0]), rand_pc());
		drain(1);
		v = rand16();
		align();
		issue(enc_i2(op_jalr, 3'd4, v[7:0]), rand_pc());
		issue(enc_ri(op_addi, link_reg, 3'd3, 5'd0), rand_pc());
		drain(2);
	endtask

	task automatic test_illegal_halt();
		opcode_e     bad [5] = '{op_ld, op_st, op_stu, op_btr, op_sco};
		logic [15:0] v;
		for (int i = 0; i < 5; i++)
		begin
			v = rand16();
			align();
			issue({bad[i], v[10:0]}, rand_pc());
			drain(1);
		end
		// Every register still holds its old value
		for (int r = 0; r < num_regs; r++)
		begin
			align();
			issue(enc_ri(op_addi, 3'(r), 3'(r), 5'd0), rand_pc());
			drain(1);
		end
		align();
		issue(enc_j(op_nop, 11'd0), rand_pc());
		drain(1);
		check_bit("halted", halted, 1'b0);
		align();
		issue(enc_j(op_halt, 11'd0), rand_pc());
		drain(1);
		align();
		issue(enc_i2(op_lbi, 3'd5, 8'h5a), rand_pc());
		wait_quiet();
		check_bit("halted", halted, 1'b1);
	endtask

	initial
	begin
		void'($urandom(32'hdfc9_675b));
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = '0;
		halt_seen   = 1'b0;
		for (int r = 0; r < num_regs; r++)
			shadow[r] = '0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		check_bit("wb.valid", wb.valid, 1'b0);
		check_bit("wb.redirect", wb.redirect, 1'b0);
		check_bit("halted", halted, 1'b0);
		test_load_consts();
		test_alu_imm();
		test_reg_ops();
		test_branches();
		test_illegal_halt();
		$display("Regression passed");
		$finish;
	end

endmodule

// File: hdl/wisc_pipe_top.sv
`timescale 1ns/1ps

module wisc_pipe_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        instr_valid,
	input  logic [wisc_pkg::word_w-1:0] instr,
	input  logic [wisc_pkg::word_w-1:0] pc,
	output wisc_pkg::wb_t               wb,
	output logic                        halted
);
	import wisc_pkg::*;

	decoded_t          dec;
	logic [word_w-1:0] rs_val;
	logic [word_w-1:0] rt_val;
	logic [word_w-1:0] rf_wdata;
	logic              rf_we;
	logic              halted_q;
	logic              issue_valid;

	// Halt shows up together with the HALT record, then sticks
	assign halted      = halted_q | (wb.valid & wb.halt);
	assign issue_valid = instr_valid & ~halted;

	always_ff @(posedge clk)
	begin
		if (rst)
			halted_q <= 1'b0;
		else if (wb.valid && wb.halt)
			halted_q <= 1'b1;
	end

	instr_decode instr_decode_inst (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (issue_valid),
		.instr       (instr),
		.pc          (pc),
		.dec         (dec)
	);

	reg_file reg_file_inst (
		.clk     (clk),
		.rst     (rst),
		.we      (rf_we),
		.waddr   (dec.rd),
		.raddr_a (dec.rs),
		.raddr_b (dec.rt),
		.wdata   (rf_wdata),
		.rdata_a (rs_val),
		.rdata_b (rt_val)
	);

	execute_stage execute_stage_inst (
		.clk      (clk),
		.rst      (rst),
		.dec      (dec),
		.rs_val   (rs_val),
		.rt_val   (rt_val),
		.rf_we    (rf_we),
		.rf_wdata (rf_wdata),
		.wb       (wb)
	);

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic                        clk,
	input  logic                        rst,
	input  wisc_pkg::decoded_t          dec,
	input  logic [wisc_pkg::word_w-1:0] rs_val,
	input  logic [wisc_pkg::word_w-1:0] rt_val,
	output logic                        rf_we,
	output logic [wisc_pkg::word_w-1:0] rf_wdata,
	output wisc_pkg::wb_t               wb
);
	import wisc_pkg::*;

	logic [word_w-1:0]   operand;
	logic [word_w-1:0]   seq_pc;
	logic [word_w-1:0]   result;
	logic [word_w-1:0]   target;
	logic [2*word_w-1:0] rot_l;
	logic [2*word_w-1:0] rot_r;
	logic [3:0]          shamt;
	logic                taken;
	wb_t                 nxt;

	// Immediate group uses imm, register group uses rt
	assign operand = (dec.op inside {op_addi, op_subi, op_xori, op_andni,
		op_roli, op_slli, op_rori, op_srli}) ? dec.imm : rt_val;
	assign seq_pc  = dec.pc + 16'd2;
	assign shamt   = operand[3:0];
	// Rotates via a doubled word
	assign rot_l   = {rs_val, rs_val} << shamt;
	assign rot_r   = {rs_val, rs_val} >> shamt;

	always_comb
	begin
		result = '0;
		taken  = 1'b0;
		target = seq_pc + dec.imm;
		case (dec.op)
			op_addi, op_subi, op_xori, op_andni, op_alu_rr:
			begin
				case (dec.fn)
					fn_add:  result = rs_val + operand;
					fn_sub:  result = operand - rs_val;
					fn_xor:  result = rs_val ^ operand;
					fn_andn: result = rs_val & ~operand;
				endcase
			end
			op_roli, op_slli, op_rori, op_srli, op_shift_rr:
			begin
				case (dec.fn)
					fn_add:  result = rot_l[2*word_w-1:word_w];
					fn_sub:  result = rs_val << shamt;
					fn_xor:  result = rot_r[word_w-1:0];
					fn_andn: result = rs_val >> shamt;
				endcase
			end
			op_seq: result = {15'b0, rs_val == rt_val};
			op_slt: result = {15'b0, $signed(rs_val) < $signed(rt_val)};
			op_sle: result = {15'b0, $signed(rs_val) <= $signed(rt_val)};
			op_lbi: result = dec.imm;
			op_slbi: result = (rs_val << 8) | dec.imm;
			op_beqz: taken = (rs_val == '0);
			op_bnez: taken = (rs_val != '0);
			op_bltz: taken = rs_val[word_w-1];
			op_bgez: taken = !rs_val[word_w-1];
			op_j: taken = 1'b1;
			op_jal:
			begin
				taken  = 1'b1;
				result = seq_pc;
			end
			op_jr:
			begin
				taken  = 1'b1;
				target = rs_val + dec.imm;
			end
			op_jalr:
			begin
				taken  = 1'b1;
				target = rs_val + dec.imm;
				result = seq_pc;
			end
			default:
			begin
				result = '0;
			end
		endcase
	end

	// Register file is written on the same edge that records wb
	assign rf_we    = dec.valid & dec.writes;
	assign rf_wdata = result;

	always_comb
	begin
		nxt.valid    = dec.valid;
		nxt.illegal  = dec.illegal;
		nxt.halt     = (dec.op == op_halt);
		nxt.writes   = dec.writes;
		nxt.rd       = dec.rd;
		nxt.data     = result;
		nxt.redirect = dec.valid & taken;
		nxt.target   = target;
	end

	always_ff @(posedge clk)
	begin
		wb <= nxt;
		if (rst)
		begin
			wb.valid    <= 1'b0;
			wb.redirect <= 1'b0;
		end
	end

	a_redirect_op: assert property (@(posedge clk) disable iff (rst)
		wb.redirect |-> $past(dec.op) inside {op_beqz, op_bnez, op_bltz, op_bgez,
			op_j, op_jr, op_jal, op_jalr});

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           we,
	input  logic [wisc_pkg::reg_idx_w-1:0] waddr,
	input  logic [wisc_pkg::reg_idx_w-1:0] raddr_a,
	input  logic [wisc_pkg::reg_idx_w-1:0] raddr_b,
	input  logic [wisc_pkg::word_w-1:0]    wdata,
	output logic [wisc_pkg::word_w-1:0]    rdata_a,
	output logic [wisc_pkg::word_w-1:0]    rdata_b
);
	import wisc_pkg::*;

	logic [word_w-1:0] regs [num_regs];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end
		else if (we)
		begin
			regs[waddr] <= wdata;
		end
	end

	// Reads see the write one cycle later, no internal bypass
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

	a_wdata_known: assert property (@(posedge clk) disable iff (rst)
		we |-> !$isunknown(wdata));

endmodule

// File: hdl/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        instr_valid,
	input  logic [wisc_pkg::word_w-1:0] instr,
	input  logic [wisc_pkg::word_w-1:0] pc,
	output wisc_pkg::decoded_t          dec
);
	import wisc_pkg::*;

	opcode_e           op;
	logic [word_w-1:0] imm_value;
	decoded_t          nxt;

	assign op = opcode_e'(instr[15:11]);

	imm_decode imm_decode_inst (
		.instr     (instr),
		.imm_value (imm_value)
	);

	always_comb
	begin
		nxt       = '0;
		nxt.valid = instr_valid;
		nxt.op    = op;
		nxt.imm   = imm_value;
		nxt.pc    = pc;
		// R-format field positions by default
		nxt.fn    = alu_fn_e'(instr[1:0]);
		nxt.rs    = instr[10:8];
		nxt.rt    = instr[7:5];
		nxt.rd    = instr[4:2];
		case (op)
			op_addi, op_subi, op_xori, op_andni,
			op_roli, op_slli, op_rori, op_srli:
			begin
				// Low opcode bits line up with the function codes
				nxt.fn     = alu_fn_e'(instr[12:11]);
				nxt.rd     = instr[7:5];
				nxt.writes = 1'b1;
			end
			op_alu_rr, op_shift_rr, op_seq, op_slt, op_sle:
			begin
				nxt.writes = 1'b1;
			end
			op_lbi, op_slbi:
			begin
				// Source doubles as destination
				nxt.rd     = instr[10:8];
				nxt.writes = 1'b1;
			end
			op_jal, op_jalr:
			begin
				nxt.rd     = link_reg;
				nxt.writes = 1'b1;
			end
			op_halt, op_nop, op_beqz, op_bnez, op_bltz, op_bgez, op_j, op_jr:
			begin
				nxt.writes = 1'b0;
			end
			default:
			begin
				// Memory ops, BTR, SCO and unused encodings
				nxt.illegal = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		dec <= nxt;
		if (rst)
			dec.valid <= 1'b0;
	end

	a_no_illegal_write: assert property (@(posedge clk) disable iff (rst)
		dec.valid |-> !(dec.illegal && dec.writes));

endmodule

// File: hdl/imm_decode.sv
`timescale 1ns/1ps

module imm_decode (
	input  logic [wisc_pkg::word_w-1:0] instr,
	output logic [wisc_pkg::word_w-1:0] imm_value
);
	import wisc_pkg::*;

	opcode_e op;

	assign op = opcode_e'(instr[15:11]);

	always_comb
	begin
		case (op)
			// 5-bit signed immediate
			op_addi, op_subi,
			op_roli, op_slli, op_rori, op_srli,
			op_st, op_ld, op_stu:
			begin
				imm_value = {{11{instr[4]}}, instr[4:0]};
			end

			// Logical ops take the immediate unsigned
			op_xori, op_andni:
			begin
				imm_value = {11'b0, instr[4:0]};
			end

			// Branch offsets, LBI constant, register jump offsets
			op_beqz, op_bnez, op_bltz, op_bgez,
			op_lbi, op_jr, op_jalr:
			begin
				imm_value = {{8{instr[7]}}, instr[7:0]};
			end

			// Low byte shifted in unsigned
			op_slbi:
			begin
				imm_value = {8'b0, instr[7:0]};
			end

			// 11-bit jump displacement
			op_j, op_jal:
			begin
				imm_value = {{5{instr[10]}}, instr[10:0]};
			end

			// No immediate in this format
			default:
			begin
				imm_value = '0;
			end
		endcase
	end

endmodule

// File: hdl/wisc_pkg.sv
package wisc_pkg;

	// Datapath widths
	localparam int word_w    = 16;
	localparam int reg_idx_w = 3;
	localparam int num_regs  = 8;

	// JAL and JALR link target
	localparam logic [reg_idx_w-1:0] link_reg = 3'd7;

	// Major opcode, instr[15:11]
	typedef enum logic [4:0] {
		op_halt     = 5'b00000,
		op_nop      = 5'b00001,
		op_j        = 5'b00100,
		op_jr       = 5'b00101,
		op_jal      = 5'b00110,
		op_jalr     = 5'b00111,
		op_addi     = 5'b01000,
		op_subi     = 5'b01001,
		op_xori     = 5'b01010,
		op_andni    = 5'b01011,
		op_beqz     = 5'b01100,
		op_bnez     = 5'b01101,
		op_bltz     = 5'b01110,
		op_bgez     = 5'b01111,
		op_st       = 5'b10000,
		op_ld       = 5'b10001,
		op_slbi     = 5'b10010,
		op_stu      = 5'b10011,
		op_roli     = 5'b10100,
		op_slli     = 5'b10101,
		op_rori     = 5'b10110,
		op_srli     = 5'b10111,
		op_lbi      = 5'b11000,
		op_btr      = 5'b11001,
		op_shift_rr = 5'b11010,
		op_alu_rr   = 5'b11011,
		op_seq      = 5'b11100,
		op_slt      = 5'b11101,
		op_sle      = 5'b11110,
		op_sco      = 5'b11111
	} opcode_e;

	// Function field; for the shift group the same codes mean rol, sll, ror, srl
	typedef enum logic [1:0] {
		fn_add  = 2'b00,
		fn_sub  = 2'b01,
		fn_xor  = 2'b10,
		fn_andn = 2'b11
	} alu_fn_e;

	typedef struct packed {
		logic                 valid;
		logic                 illegal;
		opcode_e              op;
		alu_fn_e              fn;
		logic [reg_idx_w-1:0] rs;
		logic [reg_idx_w-1:0] rt;
		logic [reg_idx_w-1:0] rd;
		logic                 writes;
		logic [word_w-1:0]    imm;
		logic [word_w-1:0]    pc;
	} decoded_t;

	typedef struct packed {
		logic                 valid;
		logic                 illegal;
		logic                 halt;
		logic                 writes;
		logic [reg_idx_w-1:0] rd;
		logic [word_w-1:0]    data;
		logic                 redirect;
		logic [word_w-1:0]    target;
	} wb_t;

endpackage
